//--- list.f
common/trap_pkg.sv
clint/clint_timer.sv
plic/plic_gateway.sv
design/machine_csr.sv
design/trap_handler.sv
design/trap_subsystem_top.sv
tb/tb_trap_subsystem.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_trap_subsystem
FILELIST  = list.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/tb_trap_subsystem.sv
// ------------------------------------------------
// trap subsystem testbench: bus and csr drivers,
// directed tests, value checks, cycle timeout
// ------------------------------------------------
`timescale 1ns/1ps

module tb_trap_subsystem
    import trap_pkg::*;
();

    localparam int n_src      = 4;
    localparam int id_w       = 3;
    // six tests need a few hundred cycles, the timer poll being longest
    localparam int max_cycles = 4000;

    logic              clk;
    logic              resetn;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [2:0]        wb_adr;
    logic [31:0]       wb_dat_w;
    logic [31:0]       wb_dat_r;
    logic              wb_ack;
    logic [n_src-1:0]  src_irq;
    logic              claim;
    logic              complete;
    logic [id_w-1:0]   complete_id;
    logic [id_w-1:0]   claim_id;
    logic              csr_we;
    logic [11:0]       csr_addr;
    logic [31:0]       csr_wdata;
    logic [31:0]       csr_rdata;
    logic              mret_commit;
    logic              exc_valid;
    logic [3:0]        exc_code;
    logic [31:0]       exc_pc;
    logic [31:0]       cur_pc;
    logic              trap_flush;
    logic [31:0]       trap_cause;
    logic [31:0]       trap_epc;
    logic              intr_happen;
    logic              ex_happen;
    logic [31:0]       trap_vector;
    logic              mtip;
    logic              msip;
    logic              meip;

    integer      seed;
    int          cycle_count = 0;
    int          flush_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          errors_at_start;
    string       test_name;
    logic [31:0] last_cause;
    logic [31:0] last_epc;
    logic        last_intr;
    logic        last_ex;

    trap_subsystem_top #(.n_sources(n_src)) dut (
        .clk (clk), .resetn (resetn),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we),
        .wb_adr (wb_adr), .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .src_irq (src_irq), .claim (claim), .complete (complete),
        .complete_id (complete_id), .claim_id (claim_id),
        .csr_we (csr_we), .csr_addr (csr_addr), .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata), .mret_commit (mret_commit),
        .exc_valid (exc_valid), .exc_code (exc_code), .exc_pc (exc_pc), .cur_pc (cur_pc),
        .trap_flush (trap_flush), .trap_cause (trap_cause), .trap_epc (trap_epc),
        .intr_happen (intr_happen), .ex_happen (ex_happen), .trap_vector (trap_vector),
        .mtip (mtip), .msip (msip), .meip (meip)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // flush monitor, sampled mid-cycle
    always @(negedge clk)
    begin
        if (trap_flush)
        begin
            flush_count = flush_count + 1;
            last_cause  = trap_cause;
            last_epc    = trap_epc;
            last_intr   = intr_happen;
            last_ex     = ex_happen;
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles)
        begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[FAIL] %s / %s: expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("error in %s: %s", test_name, msg);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic report_test();
        if (error_count == errors_at_start)
            $display("test %s: ok", test_name);
        else
            $display("test %s: %0d error(s)", test_name, error_count - errors_at_start);
    endtask

    // wishbone classic master, holds the request until ack
    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        @(posedge clk);
        #1;
        while (!wb_ack)
        begin
            @(posedge clk);
            #1;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(posedge clk);
        #1;
        while (!wb_ack)
        begin
            @(posedge clk);
            #1;
        end
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
        csr_we    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(posedge clk);
        #1;
        csr_we = 1'b0;
    endtask

    // read data is combinational from the address
    task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
        csr_addr = addr;
        #1;
        data = csr_rdata;
        @(posedge clk);
        #1;
    endtask

    task automatic mret_pulse();
        mret_commit = 1'b1;
        @(posedge clk);
        #1;
        mret_commit = 1'b0;
    endtask

    task automatic claim_source(output logic [id_w-1:0] id);
        claim = 1'b1;
        #1;
        id = claim_id;
        @(posedge clk);
        #1;
        claim = 1'b0;
    endtask

    task automatic complete_source(input logic [id_w-1:0] id);
        complete    = 1'b1;
        complete_id = id;
        @(posedge clk);
        #1;
        complete = 1'b0;
    endtask

    // waits for a flush counted after mark, gives up after limit cycles
    task automatic wait_flush(input int mark, input int limit, output bit seen);
        int n;
        n = 0;
        while (flush_count == mark && n < limit)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        seen = (flush_count != mark);
    endtask

    task automatic csr_access();
        logic [31:0] rd;
        start_test("csr_access");
        check_value("outputs after reset", 32'h0,
                    {26'b0, trap_flush, wb_ack, msip, meip, mtip, intr_happen});
        csr_write(csr_mie_addr, 32'h0000_0888);
        csr_read(csr_mie_addr, rd);
        check_value("mie", 32'h0000_0888, rd);
        csr_write(csr_mtvec_addr, 32'h8000_1003);
        csr_read(csr_mtvec_addr, rd);
        check_value("mtvec", 32'h8000_1003, rd);
        check_value("trap_vector", 32'h8000_1000, trap_vector);
        csr_read(csr_mip_addr, rd);
        check_value("mip idle", 32'h0, rd);
        csr_write(csr_mie_addr, 32'h0);
        report_test();
    endtask

    task automatic software_interrupt();
        logic [31:0] rd;
        int          mark;
        bit          seen;
        start_test("software_interrupt");
        csr_write(csr_mie_addr, 32'h1 << irq_msi_bit);
        csr_write(csr_mstatus_addr, 32'h1 << mstatus_mie_bit);
        cur_pc = $random(seed);
        mark   = flush_count;
        wb_write(clint_msip_off, 32'h1);
        wait_flush(mark, 20, seen);
        if (!seen)
            report_error("no trap after msip was set");
        check_value("trap_cause", 32'h8000_0003, last_cause);
        check_value("intr_happen", 32'h1, {31'b0, last_intr});
        check_value("ex_happen", 32'h0, {31'b0, last_ex});
        csr_read(csr_mcause_addr, rd);
        check_value("mcause", 32'h8000_0003, rd);
        csr_read(csr_mepc_addr, rd);
        check_value("mepc", cur_pc, rd);
        csr_read(csr_mstatus_addr, rd);
        check_value("mstatus on entry", 32'h0000_0080, rd);
        wb_write(clint_msip_off, 32'h0);
        check_value("flush count", 32'(mark + 1), 32'(flush_count));
        mret_pulse();
        csr_read(csr_mstatus_addr, rd);
        check_value("mstatus after mret", 32'h0000_0088, rd);
        csr_write(csr_mie_addr, 32'h0);
        report_test();
    endtask

    task automatic timer_interrupt();
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] rnd;
        logic [31:0] now_lo;
        logic [31:0] rd;
        logic [63:0] target;
        int          mark;
        int          polls;
        bit          seen;
        bit          done;
        start_test("timer_interrupt");
        csr_write(csr_mie_addr, 32'h1 << irq_mti_bit);
        csr_write(csr_mstatus_addr, 32'h1 << mstatus_mie_bit);
        wb_read(clint_mtime_lo_off, lo);
        wb_read(clint_mtime_hi_off, hi);
        rnd    = $random(seed);
        target = {hi, lo} + {32'b0, 32'd10 + (rnd % 32'd31)};
        mark   = flush_count;
        // low half first so the compare cannot match half written
        wb_write(clint_mtimecmp_lo_off, target[31:0]);
        wb_write(clint_mtimecmp_hi_off, target[63:32]);
        done  = 1'b0;
        polls = 0;
        while (!done && polls < 60)
        begin
            seen = (flush_count != mark);
            wb_read(clint_mtime_lo_off, now_lo);
            polls++;
            if (seen)
            begin
                done = 1'b1;
                check_value("mtime reached mtimecmp", 32'h1,
                            {31'b0, now_lo >= target[31:0]});
            end
        end
        if (!done)
            report_error("no timer trap after mtime passed mtimecmp");
        check_value("mtip", 32'h1, {31'b0, mtip});
        check_value("trap_cause", 32'h8000_0007, last_cause);
        csr_read(csr_mcause_addr, rd);
        check_value("mcause", 32'h8000_0007, rd);
        wb_write(clint_mtimecmp_hi_off, 32'hffff_ffff);
        csr_write(csr_mie_addr, 32'h0);
        mret_pulse();
        report_test();
    endtask

    task automatic external_interrupt();
        logic [31:0]     rd;
        logic [id_w-1:0] id;
        int              mark;
        bit              seen;
        start_test("external_interrupt");
        csr_write(csr_mie_addr, 32'h1 << irq_mei_bit);
        csr_write(csr_mstatus_addr, 32'h1 << mstatus_mie_bit);
        mark    = flush_count;
        src_irq = 4'b0101;
        wait_flush(mark, 20, seen);
        if (!seen)
            report_error("no trap after sources 1 and 3 rose");
        csr_read(csr_mcause_addr, rd);
        check_value("mcause", 32'h8000_000b, rd);
        claim_source(id);
        check_value("first claim", 32'd1, 32'(id));
        check_value("meip while in service", 32'h0, {31'b0, meip});
        claim_source(id);
        check_value("second claim", 32'd3, 32'(id));
        // new edge on source 1 while it is in service
        src_irq[0] = 1'b0;
        @(posedge clk);
        #1;
        src_irq[0] = 1'b1;
        @(posedge clk);
        #1;
        check_value("meip before complete", 32'h0, {31'b0, meip});
        complete_source(3'd1);
        complete_source(3'd3);
        check_value("repeated edge dropped", 32'd0, 32'(claim_id));
        check_value("meip after complete", 32'h0, {31'b0, meip});
        src_irq = '0;
        csr_write(csr_mie_addr, 32'h0);
        mret_pulse();
        report_test();
    endtask

    task automatic exception_masking();
        logic [31:0] rd;
        int          mark;
        bit          seen;
        start_test("exception_masking");
        csr_write(csr_mstatus_addr, 32'h0);
        csr_write(csr_mie_addr, 32'h1 << irq_msi_bit);
        mark = flush_count;
        wb_write(clint_msip_off, 32'h1);
        wait_flush(mark, 8, seen);
        check_value("flush while mie clear", 32'h0, {31'b0, seen});
        exc_pc    = $random(seed);
        exc_code  = 4'd2;
        exc_valid = 1'b1;
        @(posedge clk);
        #1;
        exc_valid = 1'b0;
        wait_flush(mark, 10, seen);
        if (!seen)
            report_error("exception did not flush");
        check_value("ex_happen", 32'h1, {31'b0, last_ex});
        check_value("intr_happen", 32'h0, {31'b0, last_intr});
        csr_read(csr_mcause_addr, rd);
        check_value("mcause exception", 32'h0000_0002, rd);
        csr_read(csr_mepc_addr, rd);
        check_value("mepc exception", exc_pc, rd);
        // mie is set one edge ahead, so the msi is enabled when the exception arrives
        mark = flush_count;
        csr_write(csr_mstatus_addr, 32'h1 << mstatus_mie_bit);
        exc_pc    = $random(seed);
        exc_code  = 4'd4;
        exc_valid = 1'b1;
        @(posedge clk);
        #1;
        exc_valid = 1'b0;
        wait_flush(mark, 10, seen);
        if (!seen)
            report_error("no flush with exception and interrupt together");
        check_value("exception wins", 32'h0000_0004, last_cause);
        check_value("epc from exception", exc_pc, last_epc);
        check_value("no interrupt taken", 32'h0, {31'b0, last_intr});
        wb_write(clint_msip_off, 32'h0);
        check_value("single flush", 32'(mark + 1), 32'(flush_count));
        csr_write(csr_mie_addr, 32'h0);
        mret_pulse();
        report_test();
    endtask

    task automatic interrupt_priority();
        logic [id_w-1:0] id;
        int              mark;
        bit              seen;
        start_test("interrupt_priority");
        csr_write(csr_mstatus_addr, 32'h0);
        csr_write(csr_mie_addr, (32'h1 << irq_msi_bit) | (32'h1 << irq_mei_bit));
        wb_write(clint_msip_off, 32'h1);
        src_irq[1] = 1'b1;
        @(posedge clk);
        #1;
        @(posedge clk);
        #1;
        mark = flush_count;
        csr_write(csr_mstatus_addr, 32'h1 << mstatus_mie_bit);
        wait_flush(mark, 10, seen);
        if (!seen)
            report_error("no trap with msi and mei pending");
        check_value("first cause", 32'h8000_000b, last_cause);
        claim_source(id);
        check_value("claim", 32'd2, 32'(id));
        complete_source(3'd2);
        mark = flush_count;
        mret_pulse();
        wait_flush(mark, 10, seen);
        if (!seen)
            report_error("no trap for msi after mret");
        check_value("second cause", 32'h8000_0003, last_cause);
        wb_write(clint_msip_off, 32'h0);
        src_irq = '0;
        csr_write(csr_mie_addr, 32'h0);
        mret_pulse();
        report_test();
    endtask

    initial
    begin
        seed        = 65325;
        resetn      = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = 3'd0;
        wb_dat_w    = 32'h0;
        src_irq     = '0;
        claim       = 1'b0;
        complete    = 1'b0;
        complete_id = '0;
        csr_we      = 1'b0;
        csr_addr    = 12'h0;
        csr_wdata   = 32'h0;
        mret_commit = 1'b0;
        exc_valid   = 1'b0;
        exc_code    = 4'd0;
        exc_pc      = 32'h0;
        cur_pc      = 32'h0;
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;

        csr_access();
        software_interrupt();
        timer_interrupt();
        external_interrupt();
        exception_masking();
        interrupt_priority();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- design/trap_subsystem_top.sv
// ------------------------------------------------
// trap subsystem top: timer, gateway, csr block
// and trap handler
// ------------------------------------------------
`timescale 1ns/1ps

module trap_subsystem_top #(
    parameter int n_sources = 4,
    parameter int id_w      = $clog2(n_sources + 1)
) (
    input  logic                 clk,
    input  logic                 resetn,
    // wishbone slave, timer only
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [2:0]           wb_adr,
    input  logic [31:0]          wb_dat_w,
    output logic [31:0]          wb_dat_r,
    output logic                 wb_ack,
    // external interrupts
    input  logic [n_sources-1:0] src_irq,
    input  logic                 claim,
    input  logic                 complete,
    input  logic [id_w-1:0]      complete_id,
    output logic [id_w-1:0]      claim_id,
    // csr port
    input  logic                 csr_we,
    input  logic [11:0]          csr_addr,
    input  logic [31:0]          csr_wdata,
    output logic [31:0]          csr_rdata,
    // pipeline side
    input  logic                 mret_commit,
    input  logic                 exc_valid,
    input  logic [3:0]           exc_code,
    input  logic [31:0]          exc_pc,
    input  logic [31:0]          cur_pc,
    output logic                 trap_flush,
    output logic [31:0]          trap_cause,
    output logic [31:0]          trap_epc,
    output logic                 intr_happen,
    output logic                 ex_happen,
    output logic [31:0]          trap_vector,
    // pending lines, visible for debug
    output logic                 mtip,
    output logic                 msip,
    output logic                 meip
);

    logic [31:0] mie;
    logic [31:0] mip;
    logic [31:0] mstatus;

    clint_timer u_clint (
        .clk      (clk),      .resetn (resetn),
        .wb_cyc   (wb_cyc),   .wb_stb (wb_stb),  .wb_we (wb_we),
        .wb_adr   (wb_adr),   .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .mtip     (mtip),     .msip   (msip)
    );

    plic_gateway #(.n_sources(n_sources), .id_w(id_w)) u_plic (
        .clk      (clk),      .resetn   (resetn),   .src_irq     (src_irq),
        .claim    (claim),    .complete (complete), .complete_id (complete_id),
        .claim_id (claim_id), .meip     (meip)
    );

    machine_csr u_csr (
        .clk         (clk),         .resetn     (resetn),
        .csr_we      (csr_we),      .csr_addr   (csr_addr),  .csr_wdata (csr_wdata),
        .mtip        (mtip),        .msip       (msip),      .meip      (meip),
        .trap_flush  (trap_flush),  .trap_cause (trap_cause), .trap_epc (trap_epc),
        .mret_commit (mret_commit), .csr_rdata  (csr_rdata),
        .mie         (mie),         .mip        (mip),       .mstatus   (mstatus),
        .trap_vector (trap_vector)
    );

    trap_handler u_trap (
        .clk        (clk),        .resetn    (resetn),
        .mie        (mie),        .mip       (mip),      .mstatus  (mstatus),
        .exc_valid  (exc_valid),  .exc_code  (exc_code), .exc_pc   (exc_pc),
        .cur_pc     (cur_pc),     .trap_flush (trap_flush),
        .trap_cause (trap_cause), .trap_epc  (trap_epc),
        .intr_happen (intr_happen), .ex_happen (ex_happen)
    );

endmodule

//--- design/trap_handler.sv
// ------------------------------------------------
// trap decision: exception and interrupt priority,
// one-cycle flush with cooldown, cause encoding
// ------------------------------------------------
`timescale 1ns/1ps

module trap_handler
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic [31:0] mie,
    input  logic [31:0] mip,
    input  logic [31:0] mstatus,
    input  logic        exc_valid,
    input  logic [3:0]  exc_code,
    input  logic [31:0] exc_pc,
    input  logic [31:0] cur_pc,
    output logic        trap_flush,
    output logic [31:0] trap_cause,
    output logic [31:0] trap_epc,
    output logic        intr_happen,
    output logic        ex_happen
);

    logic [31:0] irq_active;
    logic        take_intr;
    logic        cooldown;
    mcause_u     cause_next;

    assign irq_active = mie & mip;

    // exception first, then mei > msi > mti, interrupts need mstatus.mie
    always_comb
    begin
        cause_next.raw = 32'b0;
        take_intr      = 1'b0;
        if (exc_valid)
        begin
            cause_next.fields.code = 31'(exc_code);
        end
        else if (mstatus[mstatus_mie_bit])
        begin
            take_intr = 1'b1;
            cause_next.fields.intr = 1'b1;
            if (irq_active[irq_mei_bit])
                cause_next.fields.code = 31'(irq_mei_bit);
            else if (irq_active[irq_msi_bit])
                cause_next.fields.code = 31'(irq_msi_bit);
            else if (irq_active[irq_mti_bit])
                cause_next.fields.code = 31'(irq_mti_bit);
            else
                take_intr = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            trap_flush  <= 1'b0;
            intr_happen <= 1'b0;
            ex_happen   <= 1'b0;
            cooldown    <= 1'b0;
        end
        else
        begin
            trap_flush  <= 1'b0;
            intr_happen <= 1'b0;
            ex_happen   <= 1'b0;
            cooldown    <= trap_flush;
            // skip the flush cycle and the cooldown cycle
            if (!trap_flush && !cooldown)
            begin
                trap_flush  <= exc_valid || take_intr;
                intr_happen <= take_intr;
                ex_happen   <= exc_valid;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!trap_flush && !cooldown && (exc_valid || take_intr))
        begin
            trap_cause <= cause_next.raw;
            trap_epc   <= exc_valid ? exc_pc : cur_pc;
        end
    end

    a_flush_single: assert property (@(posedge clk) disable iff (!resetn)
        trap_flush |=> !trap_flush);

endmodule

//--- design/machine_csr.sv
// ------------------------------------------------
// machine csrs: mstatus, mie, mip, mtvec, mepc,
// mcause with trap entry and mret updates
// ------------------------------------------------
`timescale 1ns/1ps

module machine_csr
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        csr_we,
    input  logic [11:0] csr_addr,
    input  logic [31:0] csr_wdata,
    input  logic        mtip,
    input  logic        msip,
    input  logic        meip,
    input  logic        trap_flush,
    input  logic [31:0] trap_cause,
    input  logic [31:0] trap_epc,
    input  logic        mret_commit,
    output logic [31:0] csr_rdata,
    output logic [31:0] mie,
    output logic [31:0] mip,
    output logic [31:0] mstatus,
    output logic [31:0] trap_vector
);

    // only the three machine interrupt enables exist
    localparam logic [31:0] irq_mask = (32'd1 << irq_msi_bit)
                                     | (32'd1 << irq_mti_bit)
                                     | (32'd1 << irq_mei_bit);

    logic        status_mie;
    logic        status_mpie;
    logic [31:0] mie_q;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    mcause_u     mcause;

    always_comb
    begin
        mstatus = 32'b0;
        mstatus[mstatus_mie_bit]  = status_mie;
        mstatus[mstatus_mpie_bit] = status_mpie;
    end

    // live pending lines, not writable
    always_comb
    begin
        mip = 32'b0;
        mip[irq_msi_bit] = msip;
        mip[irq_mti_bit] = mtip;
        mip[irq_mei_bit] = meip;
    end

    assign mie         = mie_q;
    // direct mode only
    assign trap_vector = {mtvec[31:2], 2'b00};

    always_comb
    begin
        case (csr_addr)
            csr_mstatus_addr: csr_rdata = mstatus;
            csr_mie_addr:     csr_rdata = mie_q;
            csr_mip_addr:     csr_rdata = mip;
            csr_mtvec_addr:   csr_rdata = mtvec;
            csr_mepc_addr:    csr_rdata = mepc;
            csr_mcause_addr:  csr_rdata = mcause.raw;
            default:          csr_rdata = 32'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            mie_q       <= 32'b0;
            mtvec       <= 32'b0;
            mcause.raw  <= 32'b0;
        end
        else
        begin
            if (csr_we && csr_addr == csr_mie_addr)
                mie_q <= csr_wdata & irq_mask;
            if (csr_we && csr_addr == csr_mtvec_addr)
                mtvec <= csr_wdata;

            // trap entry, then mret, then a plain write
            if (trap_flush)
            begin
                status_mpie <= status_mie;
                status_mie  <= 1'b0;
            end
            else if (mret_commit)
            begin
                status_mie  <= status_mpie;
                status_mpie <= 1'b1;
            end
            else if (csr_we && csr_addr == csr_mstatus_addr)
            begin
                status_mie  <= csr_wdata[mstatus_mie_bit];
                status_mpie <= csr_wdata[mstatus_mpie_bit];
            end

            if (trap_flush)
                mcause.raw <= trap_cause;
            else if (csr_we && csr_addr == csr_mcause_addr)
                mcause.raw <= csr_wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (trap_flush)
            mepc <= trap_epc;
        else if (csr_we && csr_addr == csr_mepc_addr)
            mepc <= csr_wdata;
    end

endmodule

//--- plic/plic_gateway.sv
// ------------------------------------------------
// external interrupt gateway: edge capture,
// pending and in-service bits, claim/complete
// ------------------------------------------------
`timescale 1ns/1ps

module plic_gateway #(
    parameter int n_sources = 4,
    parameter int id_w      = $clog2(n_sources + 1)
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic [n_sources-1:0] src_irq,
    input  logic                 claim,
    input  logic                 complete,
    input  logic [id_w-1:0]      complete_id,
    output logic [id_w-1:0]      claim_id,
    output logic                 meip
);

    logic [n_sources-1:0] src_q;
    logic [n_sources-1:0] src_rise;
    logic [n_sources-1:0] pending;
    logic [n_sources-1:0] in_service;

    assign src_rise = src_irq & ~src_q;

    // held off while any source is being serviced
    assign meip = (|pending) && !(|in_service);

    // lowest id wins, id 0 means nothing pending
    always_comb
    begin
        claim_id = '0;
        for (int i = n_sources - 1; i >= 0; i--)
        begin
            if (pending[i])
                claim_id = id_w'(i + 1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            src_q      <= '0;
            pending    <= '0;
            in_service <= '0;
        end
        else
        begin
            src_q <= src_irq;
            for (int i = 0; i < n_sources; i++)
            begin
                // a new edge is dropped while the source is busy
                if (src_rise[i] && !pending[i] && !in_service[i])
                    pending[i] <= 1'b1;
                if (claim && (claim_id == id_w'(i + 1)))
                begin
                    pending[i]    <= 1'b0;
                    in_service[i] <= 1'b1;
                end
                // complete re-arms the gateway
                if (complete && (complete_id == id_w'(i + 1)))
                    in_service[i] <= 1'b0;
            end
        end
    end

    a_complete_id_range: assert property (@(posedge clk) disable iff (!resetn)
        complete |-> (complete_id >= id_w'(1)) && (complete_id <= id_w'(n_sources)));

endmodule

//--- clint/clint_timer.sv
// ------------------------------------------------
// clint style timer: mtime, mtimecmp, msip
// behind a wishbone classic slave
// ------------------------------------------------
`timescale 1ns/1ps

module clint_timer
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        mtip,
    output logic        msip
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [31:0] rd_mux;
    logic        wb_req;
    logic        wb_wr;

    // one access per request, the master drops stb after ack
    assign wb_req = wb_cyc && wb_stb && !wb_ack;
    assign wb_wr  = wb_req && wb_we;

    // unsigned 64-bit compare
    assign mtip = (mtime >= mtimecmp);

    always_comb
    begin
        case (wb_adr)
            clint_msip_off:        rd_mux = {31'b0, msip};
            clint_mtimecmp_lo_off: rd_mux = mtimecmp[31:0];
            clint_mtimecmp_hi_off: rd_mux = mtimecmp[63:32];
            clint_mtime_lo_off:    rd_mux = mtime[31:0];
            clint_mtime_hi_off:    rd_mux = mtime[63:32];
            default:               rd_mux = 32'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            mtime    <= 64'b0;
            mtimecmp <= '1;
            msip     <= 1'b0;
            wb_ack   <= 1'b0;
        end
        else
        begin
            wb_ack <= wb_req;
            // free running, a bus write to mtime overrides the increment
            mtime  <= mtime + 64'd1;
            if (wb_wr)
            begin
                case (wb_adr)
                    clint_msip_off:        msip <= wb_dat_w[0];
                    clint_mtimecmp_lo_off: mtimecmp[31:0] <= wb_dat_w;
                    clint_mtimecmp_hi_off: mtimecmp[63:32] <= wb_dat_w;
                    clint_mtime_lo_off:    mtime <= {mtime[63:32], wb_dat_w};
                    clint_mtime_hi_off:    mtime <= {wb_dat_w, mtime[31:0]};
                    default:               ;
                endcase
            end
        end
    end

    // read data sampled with the request, valid alongside ack
    always_ff @(posedge clk)
    begin
        if (wb_req)
            wb_dat_r <= rd_mux;
    end

    // ack only answers a request seen on the previous edge
    a_ack_after_req: assert property (@(posedge clk) disable iff (!resetn)
        wb_ack |-> $past(wb_cyc && wb_stb));

    a_ack_single: assert property (@(posedge clk) disable iff (!resetn)
        wb_ack |=> !wb_ack);

endmodule

//--- common/trap_pkg.sv
// ------------------------------------------------
// machine trap constants: csr addresses, interrupt
// bit positions, clint offsets, mcause union
// ------------------------------------------------
package trap_pkg;

    // machine csr addresses
    localparam logic [11:0] csr_mstatus_addr = 12'h300;
    localparam logic [11:0] csr_mie_addr     = 12'h304;
    localparam logic [11:0] csr_mtvec_addr   = 12'h305;
    localparam logic [11:0] csr_mepc_addr    = 12'h341;
    localparam logic [11:0] csr_mcause_addr  = 12'h342;
    localparam logic [11:0] csr_mip_addr     = 12'h344;

    // mie/mip bit positions, equal to the interrupt cause codes
    localparam int irq_msi_bit = 3;
    localparam int irq_mti_bit = 7;
    localparam int irq_mei_bit = 11;

    // mstatus bits
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;

    // clint word offsets on the 3-bit wishbone address
    localparam logic [2:0] clint_msip_off        = 3'd0;
    localparam logic [2:0] clint_mtimecmp_lo_off = 3'd1;
    localparam logic [2:0] clint_mtimecmp_hi_off = 3'd2;
    localparam logic [2:0] clint_mtime_lo_off    = 3'd3;
    localparam logic [2:0] clint_mtime_hi_off    = 3'd4;

    // mcause word
    // raw is what a csr read returns, fields is how a trap builds it
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic        intr;
            logic [30:0] code;
        } fields;
    } mcause_u;

endpackage
